// File: design/phold_pkg.sv
package phold_pkg;

	typedef logic [15:0] sim_time_t;
	typedef logic [2:0]  lp_id_t;
	typedef logic [1:0]  core_id_t;
	typedef logic [15:0] rnd_t;

	typedef struct packed {
		lp_id_t    lp;
		sim_time_t ts;
	} event_t;

	typedef enum logic [2:0] {
		IDLE,
		INIT,
		READY,
		RUNNING,
		FINISHED
	} engine_state_e;

	localparam int NUM_CORE = 4;
	localparam int NUM_INIT = 4; // Initial event population

	// Timestamp increment from rnd[3:0], range 1 to 16
	function automatic sim_time_t rnd_ts_incr(rnd_t r);
		return sim_time_t'(r[3:0]) + sim_time_t'(1);
	endfunction

	// Target process from rnd[6:4]
	function automatic lp_id_t rnd_target(rnd_t r);
		return r[6:4];
	endfunction

	// Extra work cycles from rnd[9:8], total work is this plus one
	function automatic logic [1:0] rnd_work(rnd_t r);
		return r[9:8];
	endfunction

endpackage

// File: design/lfsr.sv
`timescale 1ns/1ps

module lfsr import phold_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic load,
	input  rnd_t seed,
	input  logic next,
	output rnd_t rnd
);

	rnd_t sr;
	logic fb;

	// Taps 16, 14, 13, 11
	assign fb = sr[15] ^ sr[13] ^ sr[12] ^ sr[10];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sr <= '1;
		end else if (load) begin
			sr <= (seed == '0) ? '1 : seed; // All-zero state would lock up
		end else if (next) begin
			sr <= {sr[14:0], fb};
		end
	end

	assign rnd = sr;

endmodule

// File: design/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter import phold_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [NUM_CORE-1:0] req,
	input  logic                advance,
	output logic [NUM_CORE-1:0] gnt,
	output core_id_t            gnt_id,
	output logic                gnt_vld
);

	core_id_t ptr;
	core_id_t idx;

	// Walk downward so the requester closest to ptr is written last
	always_comb begin
		gnt_id = '0;
		gnt_vld = 1'b0;
		idx = '0;
		for (int k = NUM_CORE - 1; k >= 0; k--) begin
			idx = core_id_t'((int'(ptr) + k) % NUM_CORE);
			if (req[idx]) begin
				gnt_id = idx;
				gnt_vld = 1'b1;
			end
		end
	end

	assign gnt = gnt_vld ? (NUM_CORE'(1) << gnt_id) : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr <= '0;
		end else if (advance && gnt_vld) begin
			ptr <= core_id_t'((int'(gnt_id) + 1) % NUM_CORE); // Winner drops to lowest priority
		end
	end

endmodule

// File: design/event_queue.sv
`timescale 1ns/1ps

module event_queue import phold_pkg::*; #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               clear,
	input  logic                               enq,
	input  event_t                             enq_event,
	input  logic                               deq,
	output event_t                             head,
	output logic                               empty,
	output logic [$clog2(QUEUE_DEPTH+1)-1:0]   count
);

	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	event_t           slot [QUEUE_DEPTH];
	logic [QUEUE_DEPTH-1:0] after;

	// Slots at and above the insert point, thermometer coded since slots are sorted
	always_comb begin
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			after[i] = (i >= int'(count)) || (slot[i].ts > enq_event.ts);
		end
	end

	// Equal ts stays ahead of the new entry, so ties leave in arrival order
	always_ff @(posedge clk) begin
		if (enq) begin
			if (after[0])
				slot[0] <= enq_event;
			for (int i = 1; i < QUEUE_DEPTH; i++) begin
				if (after[i])
					slot[i] <= after[i-1] ? slot[i-1] : enq_event;
			end
		end else if (deq) begin
			for (int i = 0; i < QUEUE_DEPTH - 1; i++) begin
				slot[i] <= slot[i+1];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (clear) begin
			count <= '0;
		end else if (enq) begin
			count <= count + CNT_W'(1);
		end else if (deq && !empty) begin
			count <= count - CNT_W'(1);
		end
	end

	assign empty = (count == '0);
	assign head = slot[0];

endmodule

// File: design/phold_core.sv
`timescale 1ns/1ps

module phold_core import phold_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      start_evt,
	input  event_t    evt_in,
	input  rnd_t      rnd,
	output logic      ready,
	output logic      in_flight,
	output sim_time_t cur_ts,
	output logic      new_vld,
	output event_t    new_event,
	input  logic      ack
);

	typedef enum logic [1:0] {
		CORE_IDLE,
		CORE_WORK,
		CORE_OFFER
	} core_state_e;

	core_state_e state;
	logic [1:0]  work_cnt;
	logic        take;

	assign take = start_evt && (state == CORE_IDLE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= CORE_IDLE;
			work_cnt <= '0;
		end else begin
			case (state)
				CORE_IDLE: begin
					if (take) begin
						state <= CORE_WORK;
						work_cnt <= rnd_work(rnd);
					end
				end
				CORE_WORK: begin
					if (work_cnt == '0)
						state <= CORE_OFFER;
					else
						work_cnt <= work_cnt - 2'd1;
				end
				CORE_OFFER: begin
					if (ack)
						state <= CORE_IDLE; // Held until the receive side takes it
				end
				default: state <= CORE_IDLE;
			endcase
		end
	end

	// Child event is fixed at capture, only the parent ts is kept for GVT
	always_ff @(posedge clk) begin
		if (take) begin
			cur_ts <= evt_in.ts;
			new_event.lp <= rnd_target(rnd);
			new_event.ts <= evt_in.ts + rnd_ts_incr(rnd);
		end
	end

	assign ready = (state == CORE_IDLE);
	assign in_flight = (state != CORE_IDLE);
	assign new_vld = (state == CORE_OFFER);

endmodule

// File: design/gvt_tracker.sv
`timescale 1ns/1ps

module gvt_tracker import phold_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                run,
	input  logic [NUM_CORE-1:0] in_flight,
	input  sim_time_t           cur_ts [NUM_CORE],
	input  event_t              head,
	input  logic                empty,
	output sim_time_t           gvt
);

	sim_time_t min_ts;
	logic      min_vld;

	// Lowest timestamp still live anywhere in the engine
	always_comb begin
		min_ts = head.ts;
		min_vld = !empty;
		for (int i = 0; i < NUM_CORE; i++) begin
			if (in_flight[i] && (!min_vld || cur_ts[i] < min_ts)) begin
				min_ts = cur_ts[i];
				min_vld = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gvt <= '0;
		end else if (run && min_vld) begin
			gvt <= min_ts;
		end
	end

endmodule

// File: design/phold_engine.sv
`timescale 1ns/1ps

module phold_engine import phold_pkg::*; #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      start,
	input  rnd_t      seed,
	input  sim_time_t end_time,
	output sim_time_t gvt,
	output logic      done,
	output logic      busy,
	output logic      disp_vld,
	output event_t    disp_event,
	output core_id_t  disp_core,
	output logic      enq_vld,
	output event_t    enq_event,
	output core_id_t  enq_core
);

	engine_state_e state;
	logic [$clog2(NUM_INIT)-1:0] init_cnt;
	sim_time_t end_time_q;
	logic start_run;

	logic [NUM_CORE-1:0] core_ready;
	logic [NUM_CORE-1:0] core_new_vld;
	logic [NUM_CORE-1:0] core_flight;
	logic [NUM_CORE-1:0] rcv_gnt;
	logic [NUM_CORE-1:0] disp_gnt;
	logic [NUM_CORE-1:0] start_evt;
	event_t              core_new [NUM_CORE];
	sim_time_t           core_ts [NUM_CORE];

	core_id_t rcv_id, disp_id;
	logic     rcv_any, disp_any;

	logic   enq, deq;
	event_t enq_data;
	event_t q_head;
	logic   q_empty;
	rnd_t   rnd;
	logic   gvt_run;

	assign start_run = start && (state == IDLE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:     if (start) state <= INIT;
				INIT:     if (init_cnt == ($clog2(NUM_INIT))'(NUM_INIT - 1)) state <= READY;
				READY:    state <= RUNNING;
				RUNNING:  if (gvt > end_time_q) state <= FINISHED;
				FINISHED: state <= IDLE;
				default:  state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			init_cnt <= '0;
		else if (state == INIT)
			init_cnt <= init_cnt + 1'b1;
		else
			init_cnt <= '0;
	end

	always_ff @(posedge clk) begin
		if (start_run)
			end_time_q <= end_time;
	end

	// A new event always wins over dispatch so enq and deq never meet
	assign enq = (state == INIT) || ((state == RUNNING) && rcv_any);
	assign deq = (state == RUNNING) && !rcv_any && !q_empty && disp_any;

	always_comb begin
		if (state == INIT) begin
			enq_data.lp = lp_id_t'(init_cnt);
			enq_data.ts = '0;
		end else begin
			enq_data = core_new[rcv_id];
		end
	end

	assign start_evt = deq ? disp_gnt : '0;

	// Refresh in READY too so a stale gvt from the last run never ends this one
	assign gvt_run = (state == READY) || (state == RUNNING);

	rr_arbiter rcv_arb (
		.clk     (clk),
		.rst_n   (rst_n),
		.req     (core_new_vld),
		.advance (rcv_any), // Outside RUNNING leftover events are acked and dropped
		.gnt     (rcv_gnt),
		.gnt_id  (rcv_id),
		.gnt_vld (rcv_any)
	);

	rr_arbiter disp_arb (
		.clk     (clk),
		.rst_n   (rst_n),
		.req     (core_ready),
		.advance (deq),
		.gnt     (disp_gnt),
		.gnt_id  (disp_id),
		.gnt_vld (disp_any)
	);

	event_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_queue (
		.clk       (clk),
		.rst_n     (rst_n),
		.clear     (start_run),
		.enq       (enq),
		.enq_event (enq_data),
		.deq       (deq),
		.head      (q_head),
		.empty     (q_empty),
		.count     ()
	);

	lfsr u_lfsr (
		.clk   (clk),
		.rst_n (rst_n),
		.load  (start_run),
		.seed  (seed),
		.next  (deq || (state == INIT)),
		.rnd   (rnd)
	);

	for (genvar g = 0; g < NUM_CORE; g++) begin : gen_core
		phold_core u_core (
			.clk       (clk),
			.rst_n     (rst_n),
			.start_evt (start_evt[g]),
			.evt_in    (q_head),
			.rnd       (rnd),
			.ready     (core_ready[g]),
			.in_flight (core_flight[g]),
			.cur_ts    (core_ts[g]),
			.new_vld   (core_new_vld[g]),
			.new_event (core_new[g]),
			.ack       (rcv_gnt[g])
		);
	end

	gvt_tracker u_gvt (
		.clk       (clk),
		.rst_n     (rst_n),
		.run       (gvt_run),
		.in_flight (core_flight),
		.cur_ts    (core_ts),
		.head      (q_head),
		.empty     (q_empty),
		.gvt       (gvt)
	);

	assign done = (state == FINISHED);
	assign busy = (state != IDLE);

	// Trace strobes
	assign disp_vld = deq;
	assign disp_event = q_head;
	assign disp_core = disp_id;
	assign enq_vld = enq;
	assign enq_event = enq_data;
	assign enq_core = (state == INIT) ? '0 : rcv_id;

endmodule

// File: sim/tb_phold.sv
`timescale 1ns/1ps

module tb_phold import phold_pkg::*;;

	localparam int QUEUE_DEPTH = 8;
	localparam int NUM_RUNS = 3;
	localparam int WAIT_LIMIT = 20000;

	logic      clk;
	logic      rst_n;
	logic      start;
	rnd_t      seed;
	sim_time_t end_time;
	sim_time_t gvt;
	logic      done;
	logic      busy;
	logic      disp_vld;
	event_t    disp_event;
	core_id_t  disp_core;
	logic      enq_vld;
	event_t    enq_event;
	core_id_t  enq_core;

	// Reference model state
	event_t              model_q [$];
	event_t              parent [NUM_CORE];
	rnd_t                core_rnd [NUM_CORE];
	logic [NUM_CORE-1:0] pend;
	core_id_t            disp_ptr;
	rnd_t                lfsr_m;
	sim_time_t           end_q;
	sim_time_t           prev_gvt;
	logic                in_run;
	logic                bound_on;
	logic                done_seen;
	int                  init_seen;
	int                  settle;

	phold_engine #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.seed       (seed),
		.end_time   (end_time),
		.gvt        (gvt),
		.done       (done),
		.busy       (busy),
		.disp_vld   (disp_vld),
		.disp_event (disp_event),
		.disp_core  (disp_core),
		.enq_vld    (enq_vld),
		.enq_event  (enq_event),
		.enq_core   (enq_core)
	);

	always #50 clk = ~clk;

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_mismatch(input string msg);
		fail_stop($sformatf("mismatch at %0t: %s", $time, msg));
	endtask

	task automatic check_event(input event_t got, input event_t exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s got lp %0d ts %0d, expected lp %0d ts %0d",
				what, got.lp, got.ts, exp.lp, exp.ts));
	endtask

	task automatic check_core(input core_id_t got, input core_id_t exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s got core %0d, expected %0d", what, got, exp));
	endtask

	task automatic check_time(input sim_time_t got, input sim_time_t exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s got %0d, expected %0d", what, got, exp));
	endtask

	// Fibonacci shift with taps 16 14 13 11
	function automatic rnd_t lfsr_step(input rnd_t r);
		return {r[14:0], r[15] ^ r[13] ^ r[12] ^ r[10]};
	endfunction

	// First smallest ts in arrival order
	function automatic int oldest_min_index();
		int best;
		best = 0;
		for (int i = 1; i < model_q.size(); i++) begin
			if (model_q[i].ts < model_q[best].ts)
				best = i;
		end
		return best;
	endfunction

	// Round robin pick among idle cores starting at the pointer
	function automatic core_id_t next_idle_core(input core_id_t from);
		core_id_t c;
		core_id_t pick;
		logic     found;
		pick = from;
		found = 1'b0;
		for (int k = 0; k < NUM_CORE; k++) begin
			c = core_id_t'((int'(from) + k) % NUM_CORE);
			if (!found && !pend[c]) begin
				pick = c;
				found = 1'b1;
			end
		end
		return pick;
	endfunction

	// Outputs are stable at the negedge and strobes belong to the coming edge
	task automatic observe_cycle();
		event_t    exp;
		core_id_t  exp_core;
		int        idx;
		sim_time_t live;
		logic      live_vld;
		live_vld = 1'b0;
		live = '0;
		foreach (model_q[i]) begin
			if (!live_vld || model_q[i].ts < live) begin
				live = model_q[i].ts;
				live_vld = 1'b1;
			end
		end
		for (int c = 0; c < NUM_CORE; c++) begin
			if (pend[c] && (!live_vld || parent[c].ts < live)) begin
				live = parent[c].ts;
				live_vld = 1'b1;
			end
		end
		if (bound_on) begin
			if (gvt < prev_gvt)
				report_mismatch($sformatf("gvt fell from %0d to %0d", prev_gvt, gvt));
			if (live_vld && gvt > live)
				report_mismatch($sformatf("gvt %0d above live minimum %0d", gvt, live));
			prev_gvt = gvt;
		end else if (in_run && init_seen == NUM_INIT) begin
			settle++;
			if (settle == 2) begin // First RUNNING cycle
				check_time(gvt, '0, "gvt at run start");
				bound_on = 1'b1;
				prev_gvt = gvt;
			end
		end
		if (disp_vld && enq_vld)
			fail_stop("dispatch and enqueue happened in the same cycle");
		if (enq_vld) begin
			if (!in_run)
				fail_stop("enqueue seen outside a run");
			if (init_seen < NUM_INIT) begin
				exp.lp = lp_id_t'(init_seen);
				exp.ts = '0;
				check_event(enq_event, exp, "init event");
				check_core(enq_core, '0, "init enqueue core");
				if (!busy)
					fail_stop("busy is low during init");
				lfsr_m = lfsr_step(lfsr_m);
				init_seen++;
			end else begin
				if (!pend[enq_core])
					fail_stop("enqueue from a core that holds no event");
				exp.lp = core_rnd[enq_core][6:4];
				exp.ts = parent[enq_core].ts + sim_time_t'(core_rnd[enq_core][3:0]) + 16'd1;
				check_event(enq_event, exp, "new event");
				pend[enq_core] = 1'b0;
			end
			model_q.push_back(enq_event);
		end
		if (disp_vld) begin
			if (!in_run || init_seen < NUM_INIT)
				fail_stop("dispatch seen outside a running phase");
			if (model_q.size() == 0)
				fail_stop("dispatch while the model queue is empty");
			idx = oldest_min_index();
			check_event(disp_event, model_q[idx], "dispatched event");
			if (pend[disp_core])
				fail_stop("dispatch to a core that is still working");
			exp_core = next_idle_core(disp_ptr);
			check_core(disp_core, exp_core, "dispatch core");
			disp_ptr = core_id_t'((int'(exp_core) + 1) % NUM_CORE);
			parent[disp_core] = disp_event;
			core_rnd[disp_core] = lfsr_m; // Value before this advance
			pend[disp_core] = 1'b1;
			model_q.delete(idx);
			lfsr_m = lfsr_step(lfsr_m);
		end
		if (done) begin
			if (!in_run)
				fail_stop("done pulsed outside a run or more than once");
			if (gvt <= end_q)
				report_mismatch($sformatf("done with gvt %0d not above end %0d", gvt, end_q));
			done_seen = 1'b1;
			in_run = 1'b0;
			bound_on = 1'b0;
		end
	endtask

	task automatic do_run(input int run_idx);
		rnd_t      s;
		sim_time_t et;
		int        cyc;
		s = rnd_t'($urandom_range(16'hffff, 1));
		et = sim_time_t'($urandom_range(200, 40));
		$display("run %0d seed %h end_time %0d", run_idx, s, et);
		@(negedge clk);
		observe_cycle();
		start = 1'b1;
		seed = s;
		end_time = et;
		lfsr_m = s;
		end_q = et;
		in_run = 1'b1;
		done_seen = 1'b0;
		bound_on = 1'b0;
		init_seen = 0;
		settle = 0;
		pend = '0;
		model_q.delete();
		@(negedge clk);
		observe_cycle();
		start = 1'b0;
		cyc = 0;
		while (!done_seen) begin
			if (cyc >= WAIT_LIMIT)
				fail_stop("timed out waiting for done");
			@(negedge clk);
			observe_cycle();
			cyc++;
		end
		// Leftover core events drain here and must not show up
		for (int i = 0; i < 12; i++) begin
			@(negedge clk);
			if (i == 0 && busy)
				fail_stop("busy still high after done");
			observe_cycle();
		end
	endtask

	initial begin
		void'($urandom(32'hd495_2014));
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		seed = '0;
		end_time = '0;
		in_run = 1'b0;
		bound_on = 1'b0;
		done_seen = 1'b0;
		init_seen = 0;
		settle = 0;
		pend = '0;
		disp_ptr = '0;
		lfsr_m = '1;
		end_q = '0;
		prev_gvt = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		if (done || busy || disp_vld || enq_vld)
			fail_stop("control outputs not low after reset");
		check_time(gvt, '0, "gvt after reset");
		for (int r = 0; r < NUM_RUNS; r++)
			do_run(r);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: filelist.f
design/phold_pkg.sv
design/lfsr.sv
design/rr_arbiter.sv
design/event_queue.sv
design/phold_core.sv
design/gvt_tracker.sv
design/phold_engine.sv
sim/tb_phold.sv

// File: Bender.yml
package:
  name: phold_engine

sources:
  - files:
      - design/phold_pkg.sv
      - design/lfsr.sv
      - design/rr_arbiter.sv
      - design/event_queue.sv
      - design/phold_core.sv
      - design/gvt_tracker.sv
      - design/phold_engine.sv
  - target: simulation
    files:
      - sim/tb_phold.sv
